// ==== Bender.yml ====
package:
  name: ex_stage

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/ex_pkg.sv
      - verilog/ex_stage_if.sv
      - verilog/ex_alu.sv
      - verilog/ex_stage_reg.sv
      - verilog/ex_mem_req.sv
      - verilog/ex_stage_top.sv
  - target: test
    files:
      - bench/tb_ex_stage.sv

// ==== bench/ex_golden_vectors.txt ====
// alu mem rs rt imm src2_is_imm imm_is_unsigned dest gr_we, then expected
// result exc exc_code badvaddr req_addr uncached wstrb wdata
0 0 7fffffff 00000001 0000 0 0 01 1 80000000 1 0c 80000000 00000000 0 0 00000000
1 0 7fffffff 00000001 0000 0 0 02 1 80000000 0 00 00000000 00000000 0 0 00000000
2 0 80000000 00000001 0000 0 0 03 1 7fffffff 1 0c 7fffffff 00000000 0 0 00000000
3 0 80000000 00000001 0000 0 0 04 1 7fffffff 0 00 00000000 00000000 0 0 00000000
4 0 12345678 00000000 ff0f 1 1 05 1 00005608 0 00 00000000 00000000 0 0 00000000
5 0 f0f00000 0000ffff 0000 0 0 06 1 f0f0ffff 0 00 00000000 00000000 0 0 00000000
6 0 aaaa5555 00000000 ffff 1 1 07 1 aaaaaaaa 0 00 00000000 00000000 0 0 00000000
7 0 0f0f0f0f f0000000 0000 0 0 08 1 00f0f0f0 0 00 00000000 00000000 0 0 00000000
8 0 ffffffff 00000001 0000 0 0 09 1 00000001 0 00 00000000 00000000 0 0 00000000
9 0 00000005 00000000 fff0 1 0 0a 1 00000001 0 00 00000000 00000000 0 0 00000000
a 0 00000024 00000003 0000 0 0 0b 1 00000030 0 00 00000000 00000000 0 0 00000000
b 0 00000008 80000000 0000 0 0 0c 1 00800000 0 00 00000000 00000000 0 0 00000000
c 0 00000004 80000000 0000 0 0 0d 1 f8000000 0 00 00000000 00000000 0 0 00000000
d 0 00000000 00000000 1234 1 1 0e 1 12340000 0 00 00000000 00000000 0 0 00000000
1 1 00001000 00000000 0002 1 0 0f 1 00001002 1 04 00001002 00000000 0 0 00000000
1 2 00001000 00000000 0001 1 0 10 1 00001001 1 04 00001001 00000000 0 0 00000000
1 3 00001000 00000000 0003 1 0 11 1 00001003 1 04 00001003 00000000 0 0 00000000
1 7 00001000 00000000 0001 1 0 00 0 00001001 1 05 00001001 00000000 0 0 00000000
1 8 00001000 00000000 0002 1 0 00 0 00001002 1 05 00001002 00000000 0 0 00000000
1 1 a0001000 00000000 0004 1 0 12 1 a0001004 0 00 00000000 00001004 1 0 00000000
1 4 80002000 00000000 0003 1 0 13 1 80002003 0 00 00000000 00002003 0 0 00000000
1 6 00000100 11223344 0000 1 0 00 0 00000100 0 00 00000000 00000100 0 1 44444444
1 6 00000100 11223344 0001 1 0 00 0 00000101 0 00 00000000 00000101 0 2 44444444
1 6 00000100 11223344 0002 1 0 00 0 00000102 0 00 00000000 00000102 0 4 44444444
1 6 00000100 11223344 0003 1 0 00 0 00000103 0 00 00000000 00000103 0 8 44444444
1 7 a0000200 11223344 0000 1 0 00 0 a0000200 0 00 00000000 00000200 1 3 33443344
1 7 a0000200 11223344 0002 1 0 00 0 a0000202 0 00 00000000 00000202 1 c 33443344
1 8 80000300 11223344 0000 1 0 00 0 80000300 0 00 00000000 00000300 0 f 11223344
1 9 c0000400 11223344 0000 1 0 00 0 c0000400 0 00 00000000 c0000400 0 1 00000011
1 9 c0000400 11223344 0001 1 0 00 0 c0000401 0 00 00000000 c0000400 0 3 00001122
1 9 c0000400 11223344 0002 1 0 00 0 c0000402 0 00 00000000 c0000400 0 7 00112233
1 9 c0000400 11223344 0003 1 0 00 0 c0000403 0 00 00000000 c0000400 0 f 11223344
1 a 00000500 11223344 0000 1 0 00 0 00000500 0 00 00000000 00000500 0 f 11223344
1 a 00000500 11223344 0001 1 0 00 0 00000501 0 00 00000000 00000501 0 e 22334400
1 a 00000500 11223344 0002 1 0 00 0 00000502 0 00 00000000 00000502 0 c 33440000
1 a 00000500 11223344 0003 1 0 00 0 00000503 0 00 00000000 00000503 0 8 44000000

// ==== bench/tb_ex_stage.sv ====
`timescale 1ns/100ps
`include "ex_consts.svh"

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_FIELDS   = 17;
    localparam int MAX_VEC      = 64;
    // column positions in one vector line
    localparam int F_ALU = 0, F_MEM = 1, F_RS = 2, F_RT = 3, F_IMM = 4, F_SRC2IMM = 5;
    localparam int F_UNS = 6, F_DEST = 7, F_WE = 8, F_RESULT = 9, F_EXC = 10, F_CODE = 11;
    localparam int F_BADV = 12, F_ADDR = 13, F_UNC = 14, F_STRB = 15, F_WDATA = 16;

    logic clk, reset, ds_valid, es_allowin, ds_src2_is_imm, ds_imm_is_unsigned, ds_gr_we;
    alu_op_e   ds_alu_op;
    mem_op_e   ds_mem_op;
    word_t     ds_rs_value, ds_rt_value, ms_result, ms_badvaddr;
    logic [15:0] ds_imm;
    reg_idx_t  ds_dest, ms_dest;
    logic      ms_allowin, es_to_ms_valid, ms_gr_we, ms_exc, data_addr_ok;
    exc_code_t ms_exc_code;
    logic      data_req_valid, data_req_wr, data_req_uncached;
    word_t     data_req_addr, data_req_wdata;
    strb_t     data_req_wstrb;

    logic [`EX_XLEN-1:0] golden [0:NUM_FIELDS*MAX_VEC-1];
    int     req_list[$];  // vectors expected to reach the cache
    int     num_vec = 0;
    int     ms_idx = 0;
    int     req_idx = 0;
    int     rst_edges = 0;
    int     ms_errors = 0;
    int     req_errors = 0;
    int     flow_errors = 0;
    integer seed = 32'h7bc749dd;

    ex_stage_top i_dut (.*);

    function automatic logic [`EX_XLEN-1:0] vec_field(input int v, input int f);
        return golden[v*NUM_FIELDS + f];
    endfunction

    task automatic compare_field(input int v, input string what, input logic [31:0] exp,
                                 input logic [31:0] act, inout int errs);
        assert (act === exp) else begin
            $display("FAIL vec%0d %s: expected %h, actual %h", v, what, exp, act);
            errs++;
        end
    endtask

    task automatic drive_vector(input int v);
        ds_valid           = 1'b1;
        ds_alu_op          = alu_op_e'(4'(vec_field(v, F_ALU)));
        ds_mem_op          = mem_op_e'(4'(vec_field(v, F_MEM)));
        ds_rs_value        = vec_field(v, F_RS);
        ds_rt_value        = vec_field(v, F_RT);
        ds_imm             = 16'(vec_field(v, F_IMM));
        ds_src2_is_imm     = vec_field(v, F_SRC2IMM) != 0;
        ds_imm_is_unsigned = vec_field(v, F_UNS) != 0;
        ds_dest            = reg_idx_t'(vec_field(v, F_DEST));
        ds_gr_we           = vec_field(v, F_WE) != 0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // random back-pressure from the memory stage and the cache
    always @(posedge clk) begin
        #1;
        ms_allowin   = ($random(seed) & 3) != 0;
        data_addr_ok = ($random(seed) & 1) != 0;
    end

    initial begin
        reset = 1'b1;
        ds_valid = 1'b0;
        ds_alu_op = ALU_ADD;
        ds_mem_op = MEM_NONE;
        ds_rs_value = '0;
        ds_rt_value = '0;
        ds_imm = '0;
        ds_src2_is_imm = 1'b0;
        ds_imm_is_unsigned = 1'b0;
        ds_dest = '0;
        ds_gr_we = 1'b0;
        ms_allowin = 1'b0;
        data_addr_ok = 1'b0;
        $readmemh("bench/ex_golden_vectors.txt", golden);
        while (num_vec < MAX_VEC && !$isunknown(vec_field(num_vec, F_ALU))) begin
            if (vec_field(num_vec, F_MEM) != 0 && vec_field(num_vec, F_EXC) == 0)
                req_list.push_back(num_vec);
            num_vec++;
        end
        assert (num_vec > 0) else begin
            $display("no vectors could be read from the vector file");
            flow_errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        for (int v = 0; v < num_vec; v++) begin
            drive_vector(v);
            do @(posedge clk); while (!es_allowin);  // held until taken
            #1;
        end
        ds_valid = 1'b0;
        wait (ms_idx >= num_vec && req_idx >= req_list.size());
        repeat (5) @(posedge clk);  // room for a stray extra hand-off
        $display("errors: hand-off %0d, cache %0d, flow %0d", ms_errors, req_errors, flow_errors);
        if (ms_errors + req_errors + flow_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // memory stage side also watches the outputs during reset
    always @(posedge clk) begin
        if (reset) begin
            if (rst_edges > 0) begin
                assert (!es_to_ms_valid && !data_req_valid && es_allowin) else begin
                    $display("outputs active or es_allowin low while reset is asserted");
                    flow_errors++;
                end
            end
            rst_edges++;
        end else if (es_to_ms_valid && ms_allowin) begin
            assert (ms_idx < num_vec) else begin
                $display("hand-off to the memory stage after the last vector");
                flow_errors++;
            end
            if (ms_idx < num_vec) begin
                compare_field(ms_idx, "ms_result", vec_field(ms_idx, F_RESULT), ms_result,
                              ms_errors);
                compare_field(ms_idx, "ms_exc", vec_field(ms_idx, F_EXC), ms_exc, ms_errors);
                compare_field(ms_idx, "ms_dest", vec_field(ms_idx, F_DEST), ms_dest, ms_errors);
                compare_field(ms_idx, "ms_gr_we", vec_field(ms_idx, F_WE), ms_gr_we, ms_errors);
                // only a clean memory item requests, at the edge it leaves
                compare_field(ms_idx, "data_req_valid",
                              vec_field(ms_idx, F_MEM) != 0 && vec_field(ms_idx, F_EXC) == 0,
                              data_req_valid, ms_errors);
                if (vec_field(ms_idx, F_EXC) != 0) begin
                    compare_field(ms_idx, "ms_exc_code", vec_field(ms_idx, F_CODE),
                                  ms_exc_code, ms_errors);
                    compare_field(ms_idx, "ms_badvaddr", vec_field(ms_idx, F_BADV),
                                  ms_badvaddr, ms_errors);
                end
                ms_idx++;
            end
        end
    end

    // cache side
    always @(posedge clk) begin
        int v;
        if (!reset) begin
            assert (ms_allowin || !data_req_valid) else begin
                $display("data_req_valid high while ms_allowin is low");
                flow_errors++;
            end
            if (data_req_valid && data_addr_ok) begin
                assert (req_idx < req_list.size()) else begin
                    $display("cache request that no vector expects");
                    flow_errors++;
                end
                if (req_idx < req_list.size()) begin
                    v = req_list[req_idx];
                    compare_field(v, "data_req_addr", vec_field(v, F_ADDR), data_req_addr,
                                  req_errors);
                    compare_field(v, "data_req_uncached", vec_field(v, F_UNC),
                                  data_req_uncached, req_errors);
                    compare_field(v, "data_req_wstrb", vec_field(v, F_STRB), data_req_wstrb,
                                  req_errors);
                    compare_field(v, "data_req_wr", vec_field(v, F_MEM) >= MEM_SB,
                                  data_req_wr, req_errors);
                    if (vec_field(v, F_MEM) >= MEM_SB)  // loads carry no write data
                        compare_field(v, "data_req_wdata", vec_field(v, F_WDATA),
                                      data_req_wdata, req_errors);
                    req_idx++;
                end
            end
        end
    end

    // watchdog allows 40 cycles per vector on top of reset
    initial begin
        #1;
        #((RESET_CYCLES + 40 * num_vec + 20) * CLK_PERIOD);
        $display("timeout: not every vector reached the memory stage in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_stage_if.sv
verilog/ex_alu.sv
verilog/ex_stage_reg.sv
verilog/ex_mem_req.sv
verilog/ex_stage_top.sv
bench/tb_ex_stage.sv

// ==== verilog/ex_alu.sv ====
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::alu_op_e  ds_alu_op,
    input  ex_pkg::mem_op_e  ds_mem_op,
    input  ex_pkg::word_t    ds_rs_value,
    input  ex_pkg::word_t    ds_rt_value,
    input  logic [15:0]      ds_imm,
    input  logic             ds_src2_is_imm,
    input  logic             ds_imm_is_unsigned,
    input  ex_pkg::reg_idx_t ds_dest,
    input  logic             ds_gr_we,
    ex_result_if.producer    res
);
    import ex_pkg::*;

    word_t      imm_ext;
    word_t      src1;
    word_t      src2;
    alu_op_e    op;
    logic       is_sub;
    word_t      addend;
    word_t      sum;
    logic       sum_ovf;
    logic [4:0] shamt;

    assign imm_ext = ds_imm_is_unsigned ? {{(`EX_XLEN-16){1'b0}}, ds_imm}
                                        : {{(`EX_XLEN-16){ds_imm[15]}}, ds_imm};
    assign src1 = ds_rs_value;
    assign src2 = ds_src2_is_imm ? imm_ext : ds_rt_value;

    // load/store address is base + offset and never traps
    assign op = (ds_mem_op != MEM_NONE) ? ALU_ADDU : ds_alu_op;

    // one adder for add and sub
    assign is_sub = (op == ALU_SUB) || (op == ALU_SUBU);
    assign addend = is_sub ? ~src2 : src2;
    assign sum = src1 + addend + word_t'(is_sub);

    // same input signs, different result sign
    assign sum_ovf = (src1[`EX_XLEN-1] == addend[`EX_XLEN-1])
                  && (sum[`EX_XLEN-1] != src1[`EX_XLEN-1]);

    assign shamt = src1[4:0];  // shift amount from rs

    always_comb begin
        case (op)
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU: res.result = sum;
            ALU_AND:  res.result = src1 & src2;
            ALU_OR:   res.result = src1 | src2;
            ALU_XOR:  res.result = src1 ^ src2;
            ALU_NOR:  res.result = ~(src1 | src2);
            ALU_SLT:  res.result = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU: res.result = word_t'(src1 < src2);
            ALU_SLL:  res.result = src2 << shamt;
            ALU_SRL:  res.result = src2 >> shamt;
            ALU_SRA:  res.result = word_t'($signed(src2) >>> shamt);
            ALU_LUI:  res.result = {src2[15:0], {(`EX_XLEN-16){1'b0}}};
            default:  res.result = '0;
        endcase
    end

    assign res.overflow   = sum_ovf && ((op == ALU_ADD) || (op == ALU_SUB));
    assign res.mem_op     = ds_mem_op;
    assign res.store_data = ds_rt_value;
    assign res.dest       = ds_dest;
    assign res.gr_we      = ds_gr_we;

endmodule

// ==== verilog/ex_consts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths
`define EX_XLEN       32
`define EX_REG_IDX_W  5
`define EX_STRB_W     4   // one bit per byte of a word
`define EX_EXC_W      5

// exception codes as seen by the memory stage
`define EX_EXC_OV     12  // integer overflow
`define EX_EXC_ADEL   4   // address error on load
`define EX_EXC_ADES   5   // address error on store

// top address bits that select kseg0/kseg1
`define EX_KSEG_UNMAP_BITS 3

`endif

// ==== verilog/ex_mem_req.sv ====
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_mem_req (
    ex_slot_if.consumer       slot,
    input  logic              ms_allowin,
    input  logic              data_addr_ok,
    output logic              es_to_ms_valid,
    output ex_pkg::word_t     ms_result,
    output ex_pkg::reg_idx_t  ms_dest,
    output logic              ms_gr_we,
    output logic              ms_exc,
    output ex_pkg::exc_code_t ms_exc_code,
    output ex_pkg::word_t     ms_badvaddr,
    output logic              data_req_valid,
    output logic              data_req_wr,
    output logic              data_req_uncached,
    output ex_pkg::word_t     data_req_addr,
    output ex_pkg::strb_t     data_req_wstrb,
    output ex_pkg::word_t     data_req_wdata
);
    import ex_pkg::*;

    word_t                          addr;
    word_t                          va;
    word_t                          rt;
    logic [1:0]                     off;
    logic [`EX_KSEG_UNMAP_BITS-1:0] seg;
    logic                           is_load;
    logic                           is_store;
    logic                           is_mem;
    logic                           adel;
    logic                           ades;
    logic                           unmapped;
    logic                           ready;

    assign addr = slot.result;
    assign rt   = slot.store_data;
    assign off  = addr[1:0];

    assign is_load  = slot.mem_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
    assign is_store = slot.mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
    assign is_mem   = is_load || is_store;

    // halfword needs bit 0 clear, word needs both low bits clear
    assign adel = ((slot.mem_op inside {MEM_LH, MEM_LHU}) && off[0])
               || ((slot.mem_op == MEM_LW) && (off != 2'b00));
    assign ades = ((slot.mem_op == MEM_SH) && off[0])
               || ((slot.mem_op == MEM_SW) && (off != 2'b00));

    assign ms_exc = slot.overflow || adel || ades;
    assign ms_exc_code = slot.overflow ? exc_code_t'(`EX_EXC_OV)   :
                         adel          ? exc_code_t'(`EX_EXC_ADEL) :
                         ades          ? exc_code_t'(`EX_EXC_ADES) :
                                         '0;
    assign ms_badvaddr = ms_exc ? addr : '0;

    // swl writes from the word base
    assign va = (slot.mem_op == MEM_SWL) ? {addr[`EX_XLEN-1:2], 2'b00} : addr;

    // kseg0 = 100, kseg1 = 101; everything else passes unchanged
    assign seg      = va[`EX_XLEN-1 -: `EX_KSEG_UNMAP_BITS];
    assign unmapped = (seg[`EX_KSEG_UNMAP_BITS-1 -: 2] == 2'b10);
    assign data_req_uncached = unmapped && seg[0];
    assign data_req_addr = unmapped
        ? {{`EX_KSEG_UNMAP_BITS{1'b0}}, va[`EX_XLEN-`EX_KSEG_UNMAP_BITS-1:0]}
        : va;

    always_comb begin
        data_req_wstrb = '0;  // loads write nothing
        data_req_wdata = rt;
        case (slot.mem_op)
            MEM_SB: begin
                data_req_wstrb = strb_t'(1) << off;
                data_req_wdata = {4{rt[7:0]}};
            end
            MEM_SH: begin
                data_req_wstrb = off[1] ? 4'b1100 : 4'b0011;
                data_req_wdata = {2{rt[15:0]}};
            end
            MEM_SW: begin
                data_req_wstrb = 4'b1111;
            end
            MEM_SWL: begin
                // upper bytes of rt land at and below the offset
                data_req_wstrb = 4'b1111 >> (2'd3 - off);
                data_req_wdata = rt >> {(2'd3 - off), 3'b000};
            end
            MEM_SWR: begin
                // lower bytes of rt land at and above the offset
                data_req_wstrb = 4'b1111 << off;
                data_req_wdata = rt << {off, 3'b000};
            end
            default: begin
                data_req_wstrb = '0;
            end
        endcase
    end

    // memory item waits for the cache to take the address
    assign ready = !is_mem || ms_exc || data_addr_ok;
    assign slot.leave = slot.valid && ms_allowin && ready;

    assign es_to_ms_valid = slot.valid && ready;
    assign data_req_valid = slot.valid && is_mem && !ms_exc && ms_allowin;
    assign data_req_wr    = is_store;

    assign ms_result = slot.result;
    assign ms_dest   = slot.dest;
    assign ms_gr_we  = slot.gr_we;

    wr_strb_nonzero: assert property (@(posedge slot.clk) disable iff (slot.reset)
        data_req_valid && data_req_wr |-> data_req_wstrb != '0)
        else $error("store request with empty strobes");

    // requested address must be aligned for its size and the item free of overflow
    no_req_on_exc: assert property (@(posedge slot.clk) disable iff (slot.reset)
        data_req_valid |-> !slot.overflow
            && !((slot.mem_op inside {MEM_LW, MEM_SW}) && (data_req_addr[1:0] != 2'b00))
            && !((slot.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) && data_req_addr[0]))
        else $error("cache request for an excepting item");

endmodule

// ==== verilog/ex_pkg.sv ====
`include "ex_consts.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]      word_t;
    typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`EX_STRB_W-1:0]    strb_t;
    typedef logic [`EX_EXC_W-1:0]     exc_code_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,  // traps on overflow
        ALU_ADDU = 4'h1,
        ALU_SUB  = 4'h2,  // traps on overflow
        ALU_SUBU = 4'h3,
        ALU_AND  = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_NOR  = 4'h7,
        ALU_SLT  = 4'h8,
        ALU_SLTU = 4'h9,
        ALU_SLL  = 4'ha,
        ALU_SRL  = 4'hb,
        ALU_SRA  = 4'hc,
        ALU_LUI  = 4'hd
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE = 4'h0,
        MEM_LW   = 4'h1,
        MEM_LH   = 4'h2,
        MEM_LHU  = 4'h3,
        MEM_LB   = 4'h4,
        MEM_LBU  = 4'h5,
        MEM_SB   = 4'h6,
        MEM_SH   = 4'h7,
        MEM_SW   = 4'h8,
        MEM_SWL  = 4'h9,
        MEM_SWR  = 4'ha
    } mem_op_e;

endpackage

// ==== verilog/ex_stage_if.sv ====
`timescale 1ns/100ps

// combinational ALU output captured by the stage register
interface ex_result_if;
    import ex_pkg::*;

    word_t    result;
    logic     overflow;    // already limited to add/sub
    mem_op_e  mem_op;
    word_t    store_data;  // rt value
    reg_idx_t dest;
    logic     gr_we;

    modport producer (
        output result, overflow, mem_op, store_data, dest, gr_we
    );

    modport buffer (
        input result, overflow, mem_op, store_data, dest, gr_we
    );
endinterface

// registered item held in the stage plus the departure level
interface ex_slot_if (
    input logic clk,
    input logic reset
);
    import ex_pkg::*;

    logic     valid;
    word_t    result;
    logic     overflow;
    mem_op_e  mem_op;
    word_t    store_data;
    reg_idx_t dest;
    logic     gr_we;
    logic     leave;       // held item departs this cycle

    modport buffer (
        output valid, result, overflow, mem_op, store_data, dest, gr_we,
        input  leave
    );

    modport consumer (
        input  clk, reset,
        input  valid, result, overflow, mem_op, store_data, dest, gr_we,
        output leave
    );
endinterface

// ==== verilog/ex_stage_reg.sv ====
`timescale 1ns/100ps

module ex_stage_reg (
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_valid,
    output logic        es_allowin,
    ex_result_if.buffer res,
    ex_slot_if.buffer   slot
);
    logic take;

    // empty, or the held item goes this cycle
    assign es_allowin = !slot.valid || slot.leave;
    assign take = ds_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot.valid <= 1'b0;
        end else if (es_allowin) begin
            slot.valid <= ds_valid;  // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            slot.result     <= res.result;
            slot.overflow   <= res.overflow;
            slot.mem_op     <= res.mem_op;
            slot.store_data <= res.store_data;
            slot.dest       <= res.dest;
            slot.gr_we      <= res.gr_we;
        end
    end

    // a stalled item must not change under the memory stage or the cache
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        slot.valid && !slot.leave |=>
            $stable(slot.result) && $stable(slot.overflow) && $stable(slot.mem_op)
            && $stable(slot.store_data) && $stable(slot.dest) && $stable(slot.gr_we))
        else $error("stage item changed while stalled");

endmodule

// ==== verilog/ex_stage_top.sv ====
`timescale 1ns/100ps

module ex_stage_top (
    input  logic              clk,
    input  logic              reset,
    // decode side
    input  logic              ds_valid,
    output logic              es_allowin,
    input  ex_pkg::alu_op_e   ds_alu_op,
    input  ex_pkg::mem_op_e   ds_mem_op,
    input  ex_pkg::word_t     ds_rs_value,
    input  ex_pkg::word_t     ds_rt_value,
    input  logic [15:0]       ds_imm,
    input  logic              ds_src2_is_imm,
    input  logic              ds_imm_is_unsigned,
    input  ex_pkg::reg_idx_t  ds_dest,
    input  logic              ds_gr_we,
    // memory stage side
    input  logic              ms_allowin,
    output logic              es_to_ms_valid,
    output ex_pkg::word_t     ms_result,
    output ex_pkg::reg_idx_t  ms_dest,
    output logic              ms_gr_we,
    output logic              ms_exc,
    output ex_pkg::exc_code_t ms_exc_code,
    output ex_pkg::word_t     ms_badvaddr,
    // data cache
    output logic              data_req_valid,
    output logic              data_req_wr,
    output logic              data_req_uncached,
    output ex_pkg::word_t     data_req_addr,
    output ex_pkg::strb_t     data_req_wstrb,
    output ex_pkg::word_t     data_req_wdata,
    input  logic              data_addr_ok
);

    ex_result_if res_if ();
    ex_slot_if   slot_if (.clk(clk), .reset(reset));

    ex_alu u_alu (
        .ds_alu_op          (ds_alu_op),
        .ds_mem_op          (ds_mem_op),
        .ds_rs_value        (ds_rs_value),
        .ds_rt_value        (ds_rt_value),
        .ds_imm             (ds_imm),
        .ds_src2_is_imm     (ds_src2_is_imm),
        .ds_imm_is_unsigned (ds_imm_is_unsigned),
        .ds_dest            (ds_dest),
        .ds_gr_we           (ds_gr_we),
        .res                (res_if.producer)
    );

    ex_stage_reg u_stage_reg (
        .clk        (clk),
        .reset      (reset),
        .ds_valid   (ds_valid),
        .es_allowin (es_allowin),
        .res        (res_if.buffer),
        .slot       (slot_if.buffer)
    );

    ex_mem_req u_mem_req (
        .slot              (slot_if.consumer),
        .ms_allowin        (ms_allowin),
        .data_addr_ok      (data_addr_ok),
        .es_to_ms_valid    (es_to_ms_valid),
        .ms_result         (ms_result),
        .ms_dest           (ms_dest),
        .ms_gr_we          (ms_gr_we),
        .ms_exc            (ms_exc),
        .ms_exc_code       (ms_exc_code),
        .ms_badvaddr       (ms_badvaddr),
        .data_req_valid    (data_req_valid),
        .data_req_wr       (data_req_wr),
        .data_req_uncached (data_req_uncached),
        .data_req_addr     (data_req_addr),
        .data_req_wstrb    (data_req_wstrb),
        .data_req_wdata    (data_req_wdata)
    );

endmodule
